// File: src/cachePkg.sv
`default_nettype none

package cachePkg;
	// geometry
	localparam int numWays = 2;
	localparam int numSets = 16;
	localparam int wordsPerLine = 4;
	localparam int wordWidth = 32;
	localparam int addrWidth = 16;

	// address split: tag | index | word | byte
	localparam int byteBits = 2;
	localparam int wordBits = 2;
	localparam int offsetBits = byteBits + wordBits;
	localparam int indexBits = 4;
	localparam int tagBits = addrWidth - indexBits - offsetBits;

	typedef logic [tagBits-1:0] tagT;
	typedef logic [indexBits-1:0] indexT;
	typedef logic [wordBits-1:0] wordSelT;
	typedef logic [wordWidth-1:0] wordT;
	typedef wordT [wordsPerLine-1:0] lineT; // word 0 in the low bits

	typedef enum logic {
		opRead,
		opWrite
	} cacheOpE;

	typedef struct packed {
		logic valid;
		cacheOpE op;
		logic [addrWidth-1:0] addr;
		wordT wdata;
	} cpuReqT;

	typedef struct packed {
		logic done;
		logic hit; // hit on first lookup
		wordT rdata;
	} cpuRespT;
endpackage

`default_nettype wire

// File: src/busPkg.sv
`default_nettype none

package busPkg;
	localparam int busAddrWidth = 16;
	localparam int busDataWidth = 32;

	// wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [busAddrWidth-1:0] adr;
		logic [busDataWidth-1:0] dat;
	} wbReqT;

	// slave to master
	typedef struct packed {
		logic ack;
		logic [busDataWidth-1:0] dat;
	} wbRespT;
endpackage

`default_nettype wire

// File: src/cacheArray.sv
`timescale 1ns/1ps
`default_nettype none

module cacheArray (
	input logic clk,
	input logic reset,
	input logic [cachePkg::addrWidth-1:0] lookupAddr,
	output logic hit,
	output logic hitWay,
	output cachePkg::wordT readWord,
	output logic victimWay,
	output logic victimDirty,
	output cachePkg::tagT victimTag,
	output cachePkg::lineT victimLine,
	input logic writeWordEn,
	input cachePkg::wordT writeWord,
	input logic fillEn,
	input cachePkg::lineT fillLine,
	input logic touchEn
);
	cachePkg::tagT tagMem [cachePkg::numWays][cachePkg::numSets];
	cachePkg::lineT dataMem [cachePkg::numWays][cachePkg::numSets];
	logic [cachePkg::numWays-1:0][cachePkg::numSets-1:0] validBits;
	logic [cachePkg::numWays-1:0][cachePkg::numSets-1:0] dirtyBits;
	logic [cachePkg::numSets-1:0] lruWay; // least recently used way per set
	logic [cachePkg::numWays-1:0] wayHit;
	cachePkg::tagT tag;
	cachePkg::indexT index;
	cachePkg::wordSelT wordSel;

	assign tag = lookupAddr[cachePkg::addrWidth-1 -: cachePkg::tagBits];
	assign index = lookupAddr[cachePkg::offsetBits +: cachePkg::indexBits];
	assign wordSel = lookupAddr[cachePkg::byteBits +: cachePkg::wordBits];

	always_comb begin
		for (int w = 0; w < cachePkg::numWays; w++) begin
			wayHit[w] = validBits[w][index] && (tagMem[w][index] == tag);
		end
	end

	assign hit = |wayHit;
	assign hitWay = wayHit[1];
	assign readWord = dataMem[hitWay][index][wordSel];

	// an empty way wins over the lru one
	assign victimWay = !validBits[0][index] ? 1'b0 :
		!validBits[1][index] ? 1'b1 : lruWay[index];
	assign victimDirty = validBits[victimWay][index] && dirtyBits[victimWay][index];
	assign victimTag = tagMem[victimWay][index];
	assign victimLine = dataMem[victimWay][index];

	always_ff @(posedge clk) begin
		if (reset) begin
			validBits <= '0;
			dirtyBits <= '0;
			lruWay <= '0;
		end else if (fillEn) begin
			validBits[victimWay][index] <= 1'b1;
			dirtyBits[victimWay][index] <= 1'b0;
			lruWay[index] <= ~victimWay;
		end else if (writeWordEn) begin
			dirtyBits[hitWay][index] <= 1'b1;
			lruWay[index] <= ~hitWay;
		end else if (touchEn) begin
			lruWay[index] <= ~hitWay;
		end
	end

	always_ff @(posedge clk) begin
		if (fillEn) begin
			tagMem[victimWay][index] <= tag;
			dataMem[victimWay][index] <= fillLine;
		end else if (writeWordEn) begin
			dataMem[hitWay][index][wordSel] <= writeWord;
		end
	end
endmodule

`default_nettype wire

// File: src/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
	input logic clk,
	input logic reset,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRespT cpuResp,
	output logic [cachePkg::addrWidth-1:0] lookupAddr,
	input logic hit,
	input logic hitWay,
	input logic victimWay,
	input logic victimDirty,
	input cachePkg::wordT readWord,
	input cachePkg::tagT victimTag,
	input cachePkg::lineT victimLine,
	output logic writeWordEn,
	output logic fillEn,
	output logic touchEn,
	output cachePkg::wordT writeWord,
	output logic fillStart,
	output logic [cachePkg::addrWidth-1:0] fillAddr,
	input logic fillDone,
	input cachePkg::lineT fillLineIn,
	output cachePkg::lineT fillLineOut,
	output logic wbLoad,
	output logic [cachePkg::addrWidth-1:0] wbAddr,
	output cachePkg::lineT wbLine,
	input logic wbBusy
);
	typedef enum logic [2:0] {idle, lookup, waitWb, filling, finish} stateE;

	stateE state;
	logic isWrite;
	logic mustWait;
	logic startMiss;
	logic [cachePkg::addrWidth-1:0] lastWbAddr; // line still being written back
	cachePkg::indexT index;

	assign lookupAddr = cpuReq.addr;
	assign isWrite = cpuReq.op == cachePkg::opWrite;
	assign index = cpuReq.addr[cachePkg::offsetBits +: cachePkg::indexBits];
	assign fillAddr = {cpuReq.addr[cachePkg::addrWidth-1:cachePkg::offsetBits],
		{cachePkg::offsetBits{1'b0}}};
	assign wbAddr = {victimTag, index, {cachePkg::offsetBits{1'b0}}};
	assign wbLine = victimLine;
	assign fillLineOut = fillLineIn;
	assign writeWord = cpuReq.wdata;

	// one write-back at a time, and never fetch a line before its write-back lands
	assign mustWait = wbBusy && (victimDirty || lastWbAddr == fillAddr);
	assign startMiss = (state == lookup && !hit && !mustWait) || (state == waitWb && !wbBusy);
	assign fillStart = startMiss;
	assign wbLoad = startMiss && victimDirty;

	assign touchEn = state == lookup && hit && !isWrite;
	assign writeWordEn = isWrite && ((state == lookup && hit) || state == finish);
	assign fillEn = state == filling && fillDone;

	assign cpuResp.done = (state == lookup && hit) || state == finish;
	assign cpuResp.hit = state == lookup;
	assign cpuResp.rdata = readWord;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (cpuReq.valid) state <= lookup;
				lookup: begin
					if (hit)
						state <= idle;
					else if (mustWait)
						state <= waitWb;
					else
						state <= filling;
				end
				waitWb: if (!wbBusy) state <= filling;
				filling: if (fillDone) state <= finish; // line installed this edge
				finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wbLoad) lastWbAddr <= wbAddr;
	end
endmodule

`default_nettype wire

// File: src/lineFill.sv
`timescale 1ns/1ps
`default_nettype none

module lineFill (
	input logic clk,
	input logic reset,
	input logic fillStart,
	input logic [cachePkg::addrWidth-1:0] fillAddr,
	output logic fillDone,
	output cachePkg::lineT fillLine,
	output busPkg::wbReqT wbReq,
	input busPkg::wbRespT wbResp
);
	logic busy;
	cachePkg::wordSelT wordCnt;
	logic [cachePkg::addrWidth-1:0] baseAddr;
	logic lastWord;

	assign lastWord = wordCnt == cachePkg::wordSelT'(cachePkg::wordsPerLine - 1);

	// classic read cycles, one word each
	assign wbReq = '{
		cyc: busy,
		stb: busy,
		we: 1'b0,
		adr: {baseAddr[cachePkg::addrWidth-1:cachePkg::offsetBits], wordCnt,
			{cachePkg::byteBits{1'b0}}},
		dat: '0
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			fillDone <= 1'b0;
			wordCnt <= '0;
		end else begin
			fillDone <= 1'b0;
			if (fillStart) begin
				busy <= 1'b1;
				wordCnt <= '0;
			end else if (busy && wbResp.ack) begin
				wordCnt <= wordCnt + 1'b1;
				if (lastWord) begin
					busy <= 1'b0;
					fillDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fillStart) baseAddr <= fillAddr;
		if (busy && wbResp.ack) fillLine[wordCnt] <= wbResp.dat;
	end
endmodule

`default_nettype wire

// File: src/writeBack.sv
`timescale 1ns/1ps
`default_nettype none

module writeBack (
	input logic clk,
	input logic reset,
	input logic wbLoad,
	input logic [cachePkg::addrWidth-1:0] wbAddr,
	input cachePkg::lineT wbLine,
	output logic wbBusy,
	output busPkg::wbReqT wbReq,
	input busPkg::wbRespT wbResp
);
	cachePkg::lineT lineBuf; // own copy, cache way is free for refill
	logic [cachePkg::addrWidth-1:0] baseAddr;
	cachePkg::wordSelT wordCnt;
	logic lastWord;

	assign lastWord = wordCnt == cachePkg::wordSelT'(cachePkg::wordsPerLine - 1);

	assign wbReq = '{
		cyc: wbBusy,
		stb: wbBusy,
		we: 1'b1,
		adr: {baseAddr[cachePkg::addrWidth-1:cachePkg::offsetBits], wordCnt,
			{cachePkg::byteBits{1'b0}}},
		dat: lineBuf[wordCnt]
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			wbBusy <= 1'b0;
			wordCnt <= '0;
		end else if (wbLoad) begin
			wbBusy <= 1'b1;
			wordCnt <= '0;
		end else if (wbBusy && wbResp.ack) begin
			wordCnt <= wordCnt + 1'b1;
			if (lastWord) wbBusy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wbLoad) begin
			lineBuf <= wbLine;
			baseAddr <= wbAddr;
		end
	end
endmodule

`default_nettype wire

// File: src/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
	input logic clk,
	input logic reset,
	input busPkg::wbReqT fillReq,
	output busPkg::wbRespT fillResp,
	input busPkg::wbReqT evictReq,
	output busPkg::wbRespT evictResp,
	output busPkg::wbReqT wbOut,
	input busPkg::wbRespT wbIn
);
	logic fillWants;
	logic evictWants;
	logic holding; // a word is in flight for owner
	logic owner; // 0 fill, 1 write-back
	logic lastServed;
	logic pick;
	logic grant;

	assign fillWants = fillReq.cyc && fillReq.stb;
	assign evictWants = evictReq.cyc && evictReq.stb;

	// round robin when both wait
	assign pick = (fillWants && evictWants) ? ~lastServed : evictWants;
	assign grant = holding ? owner : pick;

	assign wbOut = grant ? evictReq : fillReq;
	assign fillResp = '{ack: wbIn.ack && !grant, dat: wbIn.dat};
	assign evictResp = '{ack: wbIn.ack && grant, dat: wbIn.dat};

	always_ff @(posedge clk) begin
		if (reset) begin
			holding <= 1'b0;
			owner <= 1'b0;
			lastServed <= 1'b0;
		end else begin
			holding <= wbOut.cyc && wbOut.stb && !wbIn.ack;
			owner <= grant;
			if (wbIn.ack) lastServed <= grant; // re-decided after every word
		end
	end
endmodule

`default_nettype wire

// File: src/dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache (
	input logic clk,
	input logic reset,
	input cachePkg::cpuReqT cpuReq,
	output cachePkg::cpuRespT cpuResp,
	output busPkg::wbReqT wbOut,
	input busPkg::wbRespT wbIn
);
	logic [cachePkg::addrWidth-1:0] lookupAddr;
	logic hit;
	logic hitWay;
	cachePkg::wordT readWord;
	logic victimWay;
	logic victimDirty;
	cachePkg::tagT victimTag;
	cachePkg::lineT victimLine;
	logic writeWordEn;
	cachePkg::wordT writeWord;
	logic fillEn;
	logic touchEn;
	cachePkg::lineT installLine;
	logic fillStart;
	logic [cachePkg::addrWidth-1:0] fillAddr;
	logic fillDone;
	cachePkg::lineT agentLine;
	logic wbLoad;
	logic [cachePkg::addrWidth-1:0] wbAddr;
	cachePkg::lineT wbLine;
	logic wbBusy;
	busPkg::wbReqT fillReq;
	busPkg::wbRespT fillResp;
	busPkg::wbReqT evictReq;
	busPkg::wbRespT evictResp;

	cacheArray array_inst (
		.clk, .reset, .lookupAddr, .hit, .hitWay, .readWord,
		.victimWay, .victimDirty, .victimTag, .victimLine,
		.writeWordEn, .writeWord, .fillEn, .fillLine(installLine), .touchEn
	);

	cacheCtrl ctrl_inst (
		.clk, .reset, .cpuReq, .cpuResp, .lookupAddr, .hit, .hitWay,
		.victimWay, .victimDirty, .readWord, .victimTag, .victimLine,
		.writeWordEn, .fillEn, .touchEn, .writeWord, .fillStart, .fillAddr,
		.fillDone, .fillLineIn(agentLine), .fillLineOut(installLine),
		.wbLoad, .wbAddr, .wbLine, .wbBusy
	);

	lineFill fill_inst (
		.clk, .reset, .fillStart, .fillAddr, .fillDone, .fillLine(agentLine),
		.wbReq(fillReq), .wbResp(fillResp)
	);

	writeBack evict_inst (
		.clk, .reset, .wbLoad, .wbAddr, .wbLine, .wbBusy,
		.wbReq(evictReq), .wbResp(evictResp)
	);

	busArbiter arb_inst (
		.clk, .reset, .fillReq, .fillResp, .evictReq, .evictResp, .wbOut, .wbIn
	);
endmodule

`default_nettype wire

// File: sim/dataCache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dataCacheSva (
	input logic clk,
	input logic reset,
	input cachePkg::cpuRespT cpuResp,
	input busPkg::wbReqT wbOut,
	input busPkg::wbRespT wbIn
);
	int assertFails = 0;

	// a word stays on the bus until acked
	holdUntilAck: assert property (@(posedge clk) disable iff (reset)
		wbOut.stb && !wbIn.ack |=> wbOut.cyc && wbOut.stb && $stable(wbOut.adr)
			&& $stable(wbOut.we))
	else begin
		$error("wishbone request changed before its ack");
		assertFails++;
	end

	singleDone: assert property (@(posedge clk) disable iff (reset)
		cpuResp.done |=> !cpuResp.done)
	else begin
		$error("done high in two consecutive cycles");
		assertFails++;
	end

	quietAfterReset: assert property (@(posedge clk) reset |=> !wbOut.cyc && !cpuResp.done)
	else begin
		$error("bus cycle or done active right after reset");
		assertFails++;
	end
endmodule

`default_nettype wire

// File: sim/dataCacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataCacheTb;
	localparam int numWords = 256; // tags 0 to 3 only
	localparam int accessTimeout = 400;

	logic clk;
	logic reset;
	cachePkg::cpuReqT cpuReq;
	cachePkg::cpuRespT cpuResp;
	busPkg::wbReqT wbOut;
	busPkg::wbRespT wbIn;

	cachePkg::wordT slaveMem [numWords];
	cachePkg::wordT modelMem [numWords]; // latest value of every word
	logic [numWords/4-1:0] lineDirty; // written since its last fill
	logic [7:0] modelTag [16][2];
	logic [1:0] modelValid [16];
	logic [15:0] modelLru; // least recent way per set

	dataCache dataCache_inst (.clk, .reset, .cpuReq, .cpuResp, .wbOut, .wbIn);

	bind dataCache dataCacheSva sva_inst (.clk, .reset, .cpuResp, .wbOut, .wbIn);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic cachePkg::wordT initWord(input int wordIdx);
		logic [15:0] byteAddr;
		byteAddr = 16'(wordIdx * 4);
		return {byteAddr ^ 16'ha5c3, ~byteAddr};
	endfunction

	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	always @(negedge clk) begin
		if (dataCache_inst.sva_inst.assertFails != 0) begin
			$display("a bound assertion failed on the bus or processor handshake");
			abortRun();
		end
	end

	task automatic checkWord(input cachePkg::wordT got, input cachePkg::wordT exp,
		input logic [15:0] addr);
		if (got !== exp) begin
			$display("[ERROR] cpuResp.rdata at %h: got %h expected %h", addr, got, exp);
			abortRun();
		end
	endtask

	task automatic checkHit(input logic got, input logic exp, input logic [15:0] addr);
		if (got !== exp) begin
			$display("[ERROR] cpuResp.hit at %h: got %h expected %h", addr, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBusWrite(input cachePkg::wordT got, input cachePkg::wordT exp,
		input logic [15:0] addr);
		if (got !== exp) begin
			$display("[ERROR] wbOut.dat at %h: got %h expected %h", addr, got, exp);
			abortRun();
		end
	endtask

	// two-way lru tag model, returns the predicted hit
	function automatic logic accessTagModel(input logic [15:0] addr);
		int setIdx;
		int way;
		logic [7:0] tag;
		setIdx = addr[7:4];
		tag = addr[15:8];
		for (int w = 0; w < 2; w++) begin
			if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag) begin
				modelLru[setIdx] = (w == 0);
				return 1'b1;
			end
		end
		if (!modelValid[setIdx][0])
			way = 0; // empty way first
		else if (!modelValid[setIdx][1])
			way = 1;
		else
			way = modelLru[setIdx];
		modelValid[setIdx][way] = 1'b1;
		modelTag[setIdx][way] = tag;
		modelLru[setIdx] = (way == 0);
		return 1'b0;
	endfunction

	// called 1 ns after a rising edge, returns at the same point
	task automatic runAccess(input cachePkg::cacheOpE op, input logic [15:0] addr,
		input cachePkg::wordT wdata);
		int waited;
		int wordIdx;
		int lineIdx;
		logic expHit;
		cpuReq = '{valid: 1'b1, op: op, addr: addr, wdata: wdata};
		waited = 0;
		@(negedge clk);
		while (!cpuResp.done) begin
			waited++;
			if (waited > accessTimeout) begin
				$display("timeout: no done for the access at address %h", addr);
				abortRun();
			end
			@(negedge clk);
		end
		wordIdx = addr[9:2];
		lineIdx = addr[9:4];
		expHit = accessTagModel(addr);
		checkHit(cpuResp.hit, expHit, addr);
		if (!expHit) lineDirty[lineIdx] = 1'b0; // fresh copy from memory
		if (op == cachePkg::opWrite) begin
			modelMem[wordIdx] = wdata;
			lineDirty[lineIdx] = 1'b1;
		end else begin
			checkWord(cpuResp.rdata, modelMem[wordIdx], addr);
		end
		@(posedge clk);
		#1;
		cpuReq.valid = 1'b0;
	endtask

	// wishbone slave with 0 to 3 wait cycles per word
	initial begin : slave
		int waitLeft;
		int widx;
		waitLeft = -1;
		forever begin
			@(posedge clk);
			#1;
			if (wbIn.ack) begin
				wbIn.ack = 1'b0;
			end else if (!reset && wbOut.cyc && wbOut.stb) begin
				if (waitLeft < 0) waitLeft = $urandom % 4;
				if (waitLeft == 0) begin
					widx = wbOut.adr[9:2];
					if (wbOut.we) begin
						if (!lineDirty[widx / 4]) begin
							$display("bus write to line at %h that was never written", wbOut.adr);
							abortRun();
						end
						checkBusWrite(wbOut.dat, modelMem[widx], wbOut.adr);
						slaveMem[widx] = wbOut.dat;
					end else begin
						wbIn.dat = slaveMem[widx];
					end
					wbIn.ack = 1'b1;
				end
				waitLeft--;
			end
		end
	end

	initial begin
		cachePkg::cacheOpE op;
		logic [15:0] addr;
		int gap;
		int waited;
		void'($urandom(32'h2007b557));
		reset = 1'b1;
		cpuReq = '0;
		wbIn = '0;
		for (int i = 0; i < numWords; i++) begin
			slaveMem[i] = initWord(i);
			modelMem[i] = initWord(i);
		end
		lineDirty = '0;
		modelLru = '0;
		for (int s = 0; s < 16; s++) modelValid[s] = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// sweep every word once after reset
		for (int i = 0; i < numWords; i++) runAccess(cachePkg::opRead, 16'(i * 4), '0);

		for (int n = 0; n < 800; n++) begin
			op = ($urandom % 10 < 4) ? cachePkg::opWrite : cachePkg::opRead;
			addr = 16'($urandom) & 16'h03fc;
			runAccess(op, addr, $urandom);
			gap = $urandom % 3;
			repeat (gap) begin
				@(negedge clk);
				if (cpuResp.done) begin
					$display("done pulse with no request pending");
					abortRun();
				end
				@(posedge clk);
				#1;
			end
		end

		waited = 0; // trailing write-back
		while (wbOut.cyc) begin
			waited++;
			if (waited > accessTimeout) begin
				$display("timeout: bus still busy after the last access");
				abortRun();
			end
			@(posedge clk);
			#1;
		end

		if (dataCache_inst.sva_inst.assertFails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// File: compile.f
src/cachePkg.sv
src/busPkg.sv
src/cacheArray.sv
src/cacheCtrl.sv
src/lineFill.sv
src/writeBack.sv
src/busArbiter.sv
src/dataCache.sv
sim/dataCache_sva.sv
sim/dataCacheTb.sv
